/* hdl/ao_defines.svh */
/*
 * Always-on peripheral subsystem shared constants
 * Bus widths, interrupt count and the peripheral address map
 */

`ifndef AO_DEFINES_SVH
`define AO_DEFINES_SVH

// Register bus widths
`define AO_ADDR_W 32
`define AO_DATA_W 32

// Low address bits that select a register inside a peripheral window
`define AO_REG_OFFSET_W 12

// Fast interrupt lines handled by the interrupt controller
`define AO_NUM_FAST_INTR 15

// Address map, one window per peripheral
`define AO_SOC_CTRL_BASE 32'h0000_0000
`define AO_FAST_INTR_BASE 32'h0000_1000
`define AO_PERIPH_SIZE 32'h0000_1000

`endif

/* hdl/ao_reg_pkg.sv */
/*
 * Register bus types
 * Address, data word and byte strobe of the always-on register bus
 */

`include "ao_defines.svh"

package ao_reg_pkg;

  // Full bus address
  typedef logic [`AO_ADDR_W-1:0] reg_addr_t;

  // Data word, read and write
  typedef logic [`AO_DATA_W-1:0] reg_data_t;

  // One strobe bit per data byte
  typedef logic [`AO_DATA_W/8-1:0] reg_strb_t;

endpackage : ao_reg_pkg

/* hdl/ao_periph_pkg.sv */
/*
 * Always-on peripheral register map
 * Register offsets of the SoC control block and the fast interrupt controller
 */

`include "ao_defines.svh"

package ao_periph_pkg;

  // SoC control block, one word per register
  typedef enum logic [`AO_REG_OFFSET_W-1:0] {
    EXIT_VALID  = 12'h000,
    EXIT_VALUE  = 12'h004,
    BOOT_SELECT = 12'h008,
    EXEC_FLASH  = 12'h00C
  } soc_ctrl_reg_e;

  // Fast interrupt controller
  typedef enum logic [`AO_REG_OFFSET_W-1:0] {
    PENDING = 12'h000,
    CLEAR   = 12'h004,
    ENABLE  = 12'h008
  } fast_intr_reg_e;

  typedef logic [`AO_NUM_FAST_INTR-1:0] fast_intr_t;

endpackage : ao_periph_pkg

/* hdl/reg_bus_if.sv */
/*
 * Register bus interface
 * Single-cycle request with same-cycle ready, read data and error
 */

`timescale 1ns/1ps

interface reg_bus_if
  import ao_reg_pkg::*;
();

  // Request, driven by the host
  logic      valid;
  logic      write;
  reg_addr_t addr;
  reg_data_t wdata;
  reg_strb_t wstrb;

  // Response, driven by the device
  reg_data_t rdata;
  logic      error;
  logic      ready;

  modport host (
    output valid,
    output write,
    output addr,
    output wdata,
    output wstrb,
    input  rdata,
    input  error,
    input  ready
  );

  modport device (
    input  valid,
    input  write,
    input  addr,
    input  wdata,
    input  wstrb,
    output rdata,
    output error,
    output ready
  );

endinterface : reg_bus_if

/* hdl/ao_reg_demux.sv */
/*
 * Always-on register demultiplexer
 * Routes each access to the SoC control or fast interrupt window and merges responses
 */

`timescale 1ns/1ps

`include "ao_defines.svh"

module ao_reg_demux
  import ao_reg_pkg::*;
(
  reg_bus_if.device in_bus,
  reg_bus_if.host   soc_bus,
  reg_bus_if.host   intr_bus
);

  logic soc_hit;
  logic intr_hit;

  // Address falls inside the window starting at base
  function automatic logic in_window(reg_addr_t addr, reg_addr_t base);
    reg_addr_t offset;
    offset = addr - base;
    return offset < reg_addr_t'(`AO_PERIPH_SIZE);
  endfunction

  assign soc_hit  = in_window(in_bus.addr, reg_addr_t'(`AO_SOC_CTRL_BASE));
  assign intr_hit = in_window(in_bus.addr, reg_addr_t'(`AO_FAST_INTR_BASE));

  // Valid goes only to the addressed peripheral
  assign soc_bus.valid = in_bus.valid & soc_hit;
  assign soc_bus.write = in_bus.write;
  assign soc_bus.addr  = in_bus.addr;
  assign soc_bus.wdata = in_bus.wdata;
  assign soc_bus.wstrb = in_bus.wstrb;

  assign intr_bus.valid = in_bus.valid & intr_hit;
  assign intr_bus.write = in_bus.write;
  assign intr_bus.addr  = in_bus.addr;
  assign intr_bus.wdata = in_bus.wdata;
  assign intr_bus.wstrb = in_bus.wstrb;

  // Response from the answering peripheral, or a decode error
  always_comb begin
    if (soc_hit) begin
      in_bus.rdata = soc_bus.rdata;
      in_bus.error = soc_bus.error;
      in_bus.ready = soc_bus.ready;
    end else if (intr_hit) begin
      in_bus.rdata = intr_bus.rdata;
      in_bus.error = intr_bus.error;
      in_bus.ready = intr_bus.ready;
    end else begin
      // Unmapped, answered here without reaching a peripheral
      in_bus.rdata = '0;
      in_bus.error = 1'b1;
      in_bus.ready = 1'b1;
    end
  end

endmodule : ao_reg_demux

/* hdl/soc_ctrl.sv */
/*
 * SoC control block
 * Exit value and exit valid registers plus boot select and flash execution status
 */

`timescale 1ns/1ps

`include "ao_defines.svh"

module soc_ctrl
  import ao_reg_pkg::*;
  import ao_periph_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_n_i,

  reg_bus_if.device bus,

  input  logic      boot_select_i,
  input  logic      execute_from_flash_i,
  output logic      exit_valid_o,
  output reg_data_t exit_value_o
);

  logic [`AO_REG_OFFSET_W-1:0] offset;
  logic                        wr_en;

  logic      exit_valid_q;
  reg_data_t exit_value_q;

  assign offset = bus.addr[`AO_REG_OFFSET_W-1:0];
  assign wr_en  = bus.valid & bus.write;

  // Exit registers, written on the access edge
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      exit_valid_q <= 1'b0;
      exit_value_q <= '0;
    end else if (wr_en) begin
      case (offset)
        EXIT_VALID: begin
          if (bus.wstrb[0]) begin
            exit_valid_q <= bus.wdata[0];
          end
        end
        EXIT_VALUE: begin
          for (int b = 0; b < `AO_DATA_W/8; b++) begin
            if (bus.wstrb[b]) begin
              exit_value_q[8*b +: 8] <= bus.wdata[8*b +: 8];
            end
          end
        end
        default: begin
          // Status and unused offsets ignore writes
        end
      endcase
    end
  end

  // Read mux, status bits sampled live
  always_comb begin
    bus.rdata = '0;
    case (offset)
      EXIT_VALID:  bus.rdata[0] = exit_valid_q;
      EXIT_VALUE:  bus.rdata    = exit_value_q;
      BOOT_SELECT: bus.rdata[0] = boot_select_i;
      EXEC_FLASH:  bus.rdata[0] = execute_from_flash_i;
      default:     bus.rdata    = '0;
    endcase
  end

  // Always answers in the access cycle
  assign bus.ready = 1'b1;
  assign bus.error = 1'b0;

  assign exit_valid_o = exit_valid_q;
  assign exit_value_o = exit_value_q;

endmodule : soc_ctrl

/* hdl/fast_intr_ctrl.sv */
/*
 * Fast interrupt controller
 * Latches interrupt lines as pending, clears them on write-one, masks with enable
 */

`timescale 1ns/1ps

`include "ao_defines.svh"

module fast_intr_ctrl
  import ao_reg_pkg::*;
  import ao_periph_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_n_i,

  reg_bus_if.device  bus,

  input  fast_intr_t fast_intr_i,
  output fast_intr_t fast_intr_o
);

  logic [`AO_REG_OFFSET_W-1:0] offset;
  logic                        wr_en;

  fast_intr_t pending_q;
  fast_intr_t enable_q;
  fast_intr_t clear_mask;

  assign offset = bus.addr[`AO_REG_OFFSET_W-1:0];
  assign wr_en  = bus.valid & bus.write;

  // CLEAR is qualified as a whole by strobe bit 0
  assign clear_mask = (wr_en && offset == CLEAR && bus.wstrb[0]) ?
                      bus.wdata[`AO_NUM_FAST_INTR-1:0] : '0;

  // Set wins over a clear in the same cycle
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      pending_q <= '0;
    end else begin
      pending_q <= (pending_q & ~clear_mask) | fast_intr_i;
    end
  end

  // Enable mask, byte strobed
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      enable_q <= '0;
    end else if (wr_en && offset == ENABLE) begin
      for (int i = 0; i < `AO_NUM_FAST_INTR; i++) begin
        if (bus.wstrb[i/8]) begin
          enable_q[i] <= bus.wdata[i];
        end
      end
    end
  end

  always_comb begin
    bus.rdata = '0;
    case (offset)
      PENDING: bus.rdata[`AO_NUM_FAST_INTR-1:0] = pending_q;
      ENABLE:  bus.rdata[`AO_NUM_FAST_INTR-1:0] = enable_q;
      // CLEAR and unused offsets read as zero
      default: bus.rdata = '0;
    endcase
  end

  assign bus.ready = 1'b1;
  assign bus.error = 1'b0;

  assign fast_intr_o = pending_q & enable_q;

endmodule : fast_intr_ctrl

/* hdl/ao_peripheral_subsystem.sv */
/*
 * Always-on peripheral subsystem
 * Register bus decoder feeding the SoC control block and fast interrupt controller
 */

`timescale 1ns/1ps

module ao_peripheral_subsystem
  import ao_reg_pkg::*;
  import ao_periph_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_n_i,

  // Register bus
  input  logic       reg_valid_i,
  input  logic       reg_write_i,
  input  reg_addr_t  reg_addr_i,
  input  reg_data_t  reg_wdata_i,
  input  reg_strb_t  reg_wstrb_i,
  output reg_data_t  reg_rdata_o,
  output logic       reg_error_o,
  output logic       reg_ready_o,

  // SoC control
  input  logic       boot_select_i,
  input  logic       execute_from_flash_i,
  output logic       exit_valid_o,
  output reg_data_t  exit_value_o,

  // Fast interrupts
  input  fast_intr_t fast_intr_i,
  output fast_intr_t fast_intr_o
);

  reg_bus_if up_bus ();
  reg_bus_if soc_bus ();
  reg_bus_if intr_bus ();

  // Top level ports onto the upstream bus
  assign up_bus.valid = reg_valid_i;
  assign up_bus.write = reg_write_i;
  assign up_bus.addr  = reg_addr_i;
  assign up_bus.wdata = reg_wdata_i;
  assign up_bus.wstrb = reg_wstrb_i;

  assign reg_rdata_o = up_bus.rdata;
  assign reg_error_o = up_bus.error;
  assign reg_ready_o = up_bus.ready;

  ao_reg_demux ao_reg_demux_i (
    .in_bus   (up_bus.device),
    .soc_bus  (soc_bus.host),
    .intr_bus (intr_bus.host)
  );

  soc_ctrl soc_ctrl_i (
    .clk_i                (clk_i),
    .rst_n_i              (rst_n_i),
    .bus                  (soc_bus.device),
    .boot_select_i        (boot_select_i),
    .execute_from_flash_i (execute_from_flash_i),
    .exit_valid_o         (exit_valid_o),
    .exit_value_o         (exit_value_o)
  );

  fast_intr_ctrl fast_intr_ctrl_i (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .bus         (intr_bus.device),
    .fast_intr_i (fast_intr_i),
    .fast_intr_o (fast_intr_o)
  );

endmodule : ao_peripheral_subsystem

/* tb/ao_checker.sv */
/*
 * Testbench checker for the always-on peripheral subsystem
 * Cycle model of registers and decode, compares responses and outputs
 */

`timescale 1ns/1ps

`include "ao_defines.svh"

module ao_checker
  import ao_reg_pkg::*;
  import ao_periph_pkg::*;
#(
  parameter int NUM_TESTS = 5
) (
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  logic       reg_valid_i,
  input  logic       reg_write_i,
  input  reg_addr_t  reg_addr_i,
  input  reg_data_t  reg_wdata_i,
  input  reg_strb_t  reg_wstrb_i,
  input  reg_data_t  reg_rdata_i,
  input  logic       reg_error_i,
  input  logic       reg_ready_i,
  input  logic       boot_select_i,
  input  logic       execute_from_flash_i,
  input  logic       exit_valid_i,
  input  reg_data_t  exit_value_i,
  input  fast_intr_t intr_lines_i,
  input  fast_intr_t intr_out_i,
  input  logic [3:0] test_id_i,
  input  logic       test_done_i,
  output int         err_count_o
);

  logic        m_exit_valid;
  reg_data_t   m_exit_value;
  fast_intr_t  m_pending;
  fast_intr_t  m_enable;
  fast_intr_t  clr_mask;
  reg_data_t   exp_rdata;
  logic        exp_err;
  logic [11:0] off;
  logic        soc_win;
  logic        intr_win;
  int          err_count = 0;
  int          check_count = 0;
  int          test_errs = 0;

  assign err_count_o = err_count;

  function automatic string test_name(input logic [3:0] id);
    case (id)
      4'd1: return "reset values";
      4'd2: return "soc control registers";
      4'd3: return "interrupt accumulation";
      4'd4: return "clear priority";
      4'd5: return "decode errors";
      default: return "unknown";
    endcase
  endfunction

  task automatic check_val(input string what, input reg_data_t exp, input reg_data_t act);
    check_count++;
    if (act !== exp) begin
      err_count++;
      test_errs++;
      $display("FAILED %s: %s expected %h actual %h", test_name(test_id_i), what, exp, act);
    end
  endtask

  // Everything is stable at the falling edge
  always @(negedge clk_i) begin
    if (!rst_n_i) begin
      m_exit_valid = 1'b0;
      m_exit_value = '0;
      m_pending    = '0;
      m_enable     = '0;
    end else begin
      check_val("exit_valid_o", 32'(m_exit_valid), 32'(exit_valid_i));
      check_val("exit_value_o", m_exit_value, exit_value_i);
      check_val("fast_intr_o", 32'(m_pending & m_enable), 32'(intr_out_i));
      clr_mask = '0;
      if (reg_valid_i) begin
        off       = reg_addr_i[11:0];
        exp_err   = 1'b0;
        exp_rdata = '0;
        // Windows are aligned to their size
        soc_win   = (reg_addr_i / `AO_PERIPH_SIZE) == (`AO_SOC_CTRL_BASE / `AO_PERIPH_SIZE);
        intr_win  = (reg_addr_i / `AO_PERIPH_SIZE) == (`AO_FAST_INTR_BASE / `AO_PERIPH_SIZE);
        if (soc_win) begin
          case (off)
            EXIT_VALID:  exp_rdata = 32'(m_exit_valid);
            EXIT_VALUE:  exp_rdata = m_exit_value;
            BOOT_SELECT: exp_rdata = 32'(boot_select_i);
            EXEC_FLASH:  exp_rdata = 32'(execute_from_flash_i);
            default:     exp_rdata = '0;
          endcase
          if (reg_write_i && off == EXIT_VALID && reg_wstrb_i[0]) begin
            m_exit_valid = reg_wdata_i[0];
          end
          if (reg_write_i && off == EXIT_VALUE) begin
            for (int b = 0; b < 4; b++) begin
              if (reg_wstrb_i[b]) m_exit_value[8*b +: 8] = reg_wdata_i[8*b +: 8];
            end
          end
        end else if (intr_win) begin
          case (off)
            PENDING: exp_rdata = 32'(m_pending);
            ENABLE:  exp_rdata = 32'(m_enable);
            default: exp_rdata = '0;
          endcase
          if (reg_write_i && off == CLEAR && reg_wstrb_i[0]) begin
            clr_mask = reg_wdata_i[`AO_NUM_FAST_INTR-1:0];
          end
          if (reg_write_i && off == ENABLE) begin
            if (reg_wstrb_i[0]) m_enable[7:0] = reg_wdata_i[7:0];
            if (reg_wstrb_i[1]) begin
              m_enable[`AO_NUM_FAST_INTR-1:8] = reg_wdata_i[`AO_NUM_FAST_INTR-1:8];
            end
          end
        end else begin
          exp_err = 1'b1;
        end
        if (reg_ready_i !== 1'b1) begin
          err_count++;
          test_errs++;
          $display("%s: no ready response for access to %h", test_name(test_id_i), reg_addr_i);
        end else begin
          check_val("reg_error_o", 32'(exp_err), 32'(reg_error_i));
          if (!reg_write_i) check_val("reg_rdata_o", exp_rdata, reg_rdata_i);
        end
      end
      // New lines are set after the clear, so set wins
      m_pending = (m_pending & ~clr_mask) | intr_lines_i;
    end
    if (test_done_i) begin
      $display("test %0d %s finished with %0d errors", test_id_i, test_name(test_id_i), test_errs);
      test_errs = 0;
      if (test_id_i == 4'(NUM_TESTS)) begin
        $display("Summary: %0d tests, %0d checks, %0d errors", NUM_TESTS, check_count, err_count);
      end
    end
  end

endmodule : ao_checker

/* tb/tb_ao_peripheral_subsystem.sv */
/*
 * Testbench for the always-on peripheral subsystem
 * Seeded random register accesses and interrupt pulses, checked by ao_checker
 */

`timescale 1ns/1ps

`include "ao_defines.svh"

module tb_ao_peripheral_subsystem
  import ao_reg_pkg::*;
  import ao_periph_pkg::*;
();

  localparam int NUM_TESTS = 5;
  localparam int N_RAND = 40;
  // Three reset reads, then N_RAND accesses in each later test
  localparam int TOTAL_ACCESSES = 3 + (NUM_TESTS - 1) * N_RAND;

  logic       clk = 1'b0;
  logic       rst_n;
  logic       reg_valid;
  logic       reg_write;
  reg_addr_t  reg_addr;
  reg_data_t  reg_wdata;
  reg_strb_t  reg_wstrb;
  reg_data_t  reg_rdata;
  logic       reg_error;
  logic       reg_ready;
  logic       boot_select;
  logic       exec_flash;
  logic       exit_valid;
  reg_data_t  exit_value;
  fast_intr_t intr_in;
  fast_intr_t intr_out;
  logic [3:0] test_id;
  logic       test_done;
  logic       intr_on = 1'b0;
  int         err_count;
  integer     seed = 32'h9c75;

  always #4 clk = ~clk;

  ao_peripheral_subsystem ao_peripheral_subsystem_i (
    .clk_i (clk), .rst_n_i (rst_n),
    .reg_valid_i (reg_valid), .reg_write_i (reg_write), .reg_addr_i (reg_addr),
    .reg_wdata_i (reg_wdata), .reg_wstrb_i (reg_wstrb), .reg_rdata_o (reg_rdata),
    .reg_error_o (reg_error), .reg_ready_o (reg_ready),
    .boot_select_i (boot_select), .execute_from_flash_i (exec_flash),
    .exit_valid_o (exit_valid), .exit_value_o (exit_value),
    .fast_intr_i (intr_in), .fast_intr_o (intr_out)
  );

  ao_checker #(.NUM_TESTS (NUM_TESTS)) ao_checker_i (
    .clk_i (clk), .rst_n_i (rst_n),
    .reg_valid_i (reg_valid), .reg_write_i (reg_write), .reg_addr_i (reg_addr),
    .reg_wdata_i (reg_wdata), .reg_wstrb_i (reg_wstrb), .reg_rdata_i (reg_rdata),
    .reg_error_i (reg_error), .reg_ready_i (reg_ready),
    .boot_select_i (boot_select), .execute_from_flash_i (exec_flash),
    .exit_valid_i (exit_valid), .exit_value_i (exit_value),
    .intr_lines_i (intr_in), .intr_out_i (intr_out),
    .test_id_i (test_id), .test_done_i (test_done), .err_count_o (err_count)
  );

  // Random status inputs and sparse interrupt pulses, then the next edge
  task automatic step();
    logic [31:0] rnd_a;
    logic [31:0] rnd_b;
    rnd_a = $random(seed);
    rnd_b = $random(seed);
    boot_select <= rnd_a[0];
    exec_flash  <= rnd_a[1];
    intr_in     <= intr_on ? (rnd_a[`AO_NUM_FAST_INTR-1:0] & rnd_a[16 +: `AO_NUM_FAST_INTR] &
                              rnd_b[`AO_NUM_FAST_INTR-1:0]) : '0;
    @(posedge clk);
  endtask

  // One-cycle access followed by an idle gap of 0 to 2 cycles
  task automatic access(input logic write, input reg_addr_t addr, input reg_data_t wdata,
                        input reg_strb_t wstrb);
    logic [31:0] rnd;
    reg_valid <= 1'b1;
    reg_write <= write;
    reg_addr  <= addr;
    reg_wdata <= wdata;
    reg_wstrb <= wstrb;
    step();
    reg_valid <= 1'b0;
    rnd = $random(seed);
    repeat (rnd[7:0] % 3) step();
  endtask

  task automatic read_reg(input reg_addr_t addr);
    logic [31:0] rnd;
    rnd = $random(seed);
    access(1'b0, addr, rnd, rnd[3:0]);
  endtask

  function automatic reg_addr_t soc_addr(input logic [11:0] off);
    return `AO_SOC_CTRL_BASE + reg_addr_t'(off);
  endfunction

  function automatic reg_addr_t intr_addr(input logic [11:0] off);
    return `AO_FAST_INTR_BASE + reg_addr_t'(off);
  endfunction

  task automatic end_test();
    test_done <= 1'b1;
    step();
    test_done <= 1'b0;
  endtask

  initial begin
    logic [31:0] rnd;
    logic [31:0] data;
    reg_addr_t   addr;
    logic [11:0] off;
    rst_n <= 1'b0;
    reg_valid <= 1'b0;
    reg_write <= 1'b0;
    reg_addr <= '0;
    reg_wdata <= '0;
    reg_wstrb <= '0;
    boot_select <= 1'b0;
    exec_flash <= 1'b0;
    intr_in <= '0;
    test_id <= 4'd0;
    test_done <= 1'b0;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;

    test_id <= 4'd1;
    read_reg(soc_addr(EXIT_VALUE));
    read_reg(intr_addr(PENDING));
    read_reg(intr_addr(ENABLE));
    end_test();

    test_id <= 4'd2;
    for (int n = 0; n < N_RAND; n++) begin
      rnd  = $random(seed);
      data = $random(seed);
      case (rnd[2:0])
        3'd0, 3'd1: access(1'b1, soc_addr(EXIT_VALUE), data, rnd[7:4]);
        3'd2:       access(1'b1, soc_addr(EXIT_VALID), data, rnd[7:4]);
        default:    read_reg(soc_addr(12'({rnd[9:8], 2'b00})));
      endcase
    end
    end_test();

    test_id <= 4'd3;
    intr_on = 1'b1;
    for (int n = 0; n < N_RAND; n++) begin
      rnd  = $random(seed);
      data = $random(seed);
      case (rnd[1:0])
        2'd0:    access(1'b1, intr_addr(ENABLE), data, rnd[7:4]);
        2'd1:    read_reg(intr_addr(ENABLE));
        default: read_reg(intr_addr(PENDING));
      endcase
    end
    end_test();

    test_id <= 4'd4;
    for (int n = 0; n < N_RAND; n++) begin
      rnd  = $random(seed);
      data = $random(seed);
      case (rnd[1:0])
        2'd0:    access(1'b1, intr_addr(CLEAR), data, rnd[7:4]);
        2'd1:    access(1'b1, intr_addr(CLEAR), '1, 4'hF);
        2'd2:    read_reg(intr_addr(CLEAR));
        default: read_reg(intr_addr(PENDING));
      endcase
    end
    end_test();

    test_id <= 4'd5;
    for (int n = 0; n < N_RAND; n++) begin
      rnd  = $random(seed);
      data = $random(seed);
      addr = $random(seed);
      off  = rnd[27:16];
      // Low bits land on a real register offset, so a leaked write would show
      addr[`AO_REG_OFFSET_W-1:0] = 12'({rnd[11:10], 2'b00});
      if (addr < `AO_FAST_INTR_BASE + `AO_PERIPH_SIZE) addr = addr + 32'h0000_2000;
      if (off < 12'h010) off = off + 12'h010;
      case (rnd[1:0])
        2'd0, 2'd1: access(rnd[8], addr, data, rnd[7:4]);
        2'd2:       access(rnd[8], rnd[9] ? intr_addr(off) : soc_addr(off), data, rnd[7:4]);
        default:    read_reg(rnd[9] ? intr_addr(ENABLE) : soc_addr(EXIT_VALUE));
      endcase
    end
    end_test();

    repeat (2) @(posedge clk);
    if (err_count == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

  // Watchdog sized for three cycles per access
  initial begin
    #(2 * TOTAL_ACCESSES * 3 * 8);
    $display("Timeout: the tests did not finish in time");
    $display("TB FAILED");
    $finish;
  end

endmodule : tb_ao_peripheral_subsystem

/* tb.f */
+incdir+hdl
hdl/ao_reg_pkg.sv
hdl/ao_periph_pkg.sv
hdl/reg_bus_if.sv
hdl/ao_reg_demux.sv
hdl/soc_ctrl.sv
hdl/fast_intr_ctrl.sv
hdl/ao_peripheral_subsystem.sv
tb/ao_checker.sv
tb/tb_ao_peripheral_subsystem.sv

/* run.sh */
#!/bin/sh
# Compile and run the always-on peripheral subsystem testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f tb.f --top-module tb_ao_peripheral_subsystem -o tb_sim

./obj_dir/tb_sim > sim.log 2>&1
cat sim.log

if grep -qx "TB PASSED" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed, see sim.log"
  exit 1
fi
